/* hdl/pipePkg.sv */
package pipePkg;

  localparam int dataWidth = 16;
  localparam int regAddrWidth = 3;
  localparam int numRegs = 8;
  localparam int aluOpWidth = 2;

  // Major opcodes in instr[15:11]
  localparam logic [4:0] opNop = 5'b00001;
  localparam logic [4:0] opAddi = 5'b01000;
  localparam logic [4:0] opSubi = 5'b01001;
  localparam logic [4:0] opXori = 5'b01010;
  localparam logic [4:0] opAndni = 5'b01011;
  localparam logic [4:0] opLbi = 5'b11000;
  localparam logic [4:0] opRtype = 5'b11011;

  // R-format function field
  localparam logic [1:0] fnAdd = 2'b00;
  localparam logic [1:0] fnSub = 2'b01;
  localparam logic [1:0] fnXor = 2'b10;
  localparam logic [1:0] fnAndn = 2'b11;

  // Bubble word is opcode NOP with all other fields zero
  localparam logic [dataWidth-1:0] nopInstr = 16'b0000_1000_0000_0000;

  localparam logic [aluOpWidth-1:0] aluAdd = 2'd0;
  localparam logic [aluOpWidth-1:0] aluXor = 2'd1;
  localparam logic [aluOpWidth-1:0] aluAndn = 2'd2;

  typedef struct packed {
    logic [4:0] opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [1:0] funct;
  } rFmtT;

  typedef struct packed {
    logic [4:0] opcode;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rd;
    logic [4:0] imm5;
  } iFmtT;

  typedef struct packed {
    logic [4:0] opcode;
    logic [regAddrWidth-1:0] rs;
    logic [7:0] imm8;
  } lFmtT;

  typedef union packed {
    rFmtT rFmt;
    iFmtT iFmt;
    lFmtT lFmt;
  } instrWord;

endpackage

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile import pipePkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [regAddrWidth-1:0] rsAddr,
  input  logic [regAddrWidth-1:0] rtAddr,
  input  logic                    wrEn,
  input  logic [regAddrWidth-1:0] wrAddr,
  input  logic [dataWidth-1:0]    wrData,
  output logic [dataWidth-1:0]    rsData,
  output logic [dataWidth-1:0]    rtData
);

  logic [dataWidth-1:0] regs [numRegs];
  logic rsHit;
  logic rtHit;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Write-through so decode sees the value being written back this cycle
  assign rsHit = wrEn && (wrAddr == rsAddr);
  assign rtHit = wrEn && (wrAddr == rtAddr);

  always_comb begin
    rsData = rsHit ? wrData : regs[rsAddr];
    rtData = rtHit ? wrData : regs[rtAddr];
  end

  // Writeback from execute must always name a real register
  wrAddrKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    wrEn |-> !$isunknown(wrAddr)
  ) else $error("regFile: write enabled with unknown wrAddr");

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/1ps

module instrDecode import pipePkg::*; (
  input  logic [dataWidth-1:0]    instr,
  input  logic                    instrValid,
  output logic [regAddrWidth-1:0] rsAddr,
  output logic [regAddrWidth-1:0] rtAddr,
  output logic [regAddrWidth-1:0] writeReg,
  output logic                    regWrite,
  output logic                    readingRs,
  output logic                    readingRt,
  output logic                    aluSrc2,
  output logic                    invA,
  output logic                    invB,
  output logic                    cin,
  output logic [aluOpWidth-1:0]   aluOp,
  output logic [dataWidth-1:0]    imm,
  output instrWord                decInstr
);

  instrWord iw;
  logic [dataWidth-1:0] sExt5;
  logic [dataWidth-1:0] zExt5;
  logic [dataWidth-1:0] sExt8;

  assign iw = instr;

  // Source fields sit in the same bits in every format
  assign rsAddr = iw.rFmt.rs;
  assign rtAddr = iw.rFmt.rt;

  assign sExt5 = {{(dataWidth-5){iw.iFmt.imm5[4]}}, iw.iFmt.imm5};
  assign zExt5 = {{(dataWidth-5){1'b0}}, iw.iFmt.imm5};
  assign sExt8 = {{(dataWidth-8){iw.lFmt.imm8[7]}}, iw.lFmt.imm8};

  always_comb begin
    writeReg = iw.iFmt.rd;
    regWrite = 1'b0;
    readingRs = 1'b0;
    readingRt = 1'b0;
    aluSrc2 = 1'b1;
    invA = 1'b0;
    invB = 1'b0;
    cin = 1'b0;
    aluOp = aluAdd;
    imm = sExt5;
    decInstr = instr;
    if (!instrValid) begin
      decInstr = nopInstr;
    end else begin
      case (iw.rFmt.opcode)
        opAddi: begin
          regWrite = 1'b1;
          readingRs = 1'b1;
        end
        opSubi: begin
          // imm - rs computed as imm + ~rs + 1
          regWrite = 1'b1;
          readingRs = 1'b1;
          invA = 1'b1;
          cin = 1'b1;
        end
        opXori: begin
          regWrite = 1'b1;
          readingRs = 1'b1;
          aluOp = aluXor;
          imm = zExt5;
        end
        opAndni: begin
          regWrite = 1'b1;
          readingRs = 1'b1;
          aluOp = aluAndn;
          invB = 1'b1;
          imm = zExt5;
        end
        opLbi: begin
          // No source read, so operand A arrives as zero
          writeReg = iw.lFmt.rs;
          regWrite = 1'b1;
          imm = sExt8;
        end
        opRtype: begin
          writeReg = iw.rFmt.rd;
          regWrite = 1'b1;
          readingRs = 1'b1;
          readingRt = 1'b1;
          aluSrc2 = 1'b0;
          case (iw.rFmt.funct)
            fnSub: begin
              invA = 1'b1;
              cin = 1'b1;
            end
            fnXor: aluOp = aluXor;
            fnAndn: begin
              aluOp = aluAndn;
              invB = 1'b1;
            end
            default: aluOp = aluAdd;
          endcase
        end
        default: begin
          // NOP and unknown opcodes
          aluSrc2 = 1'b0;
          decInstr = nopInstr;
        end
      endcase
    end
  end

endmodule

/* hdl/hazardDetect.sv */
`timescale 1ns/1ps

module hazardDetect import pipePkg::*; (
  input  logic [regAddrWidth-1:0] rsAddr,
  input  logic [regAddrWidth-1:0] rtAddr,
  input  logic                    readingRs,
  input  logic                    readingRt,
  input  logic                    instrValid,
  input  logic                    exRegWrite,
  input  logic [regAddrWidth-1:0] exWriteReg,
  output logic                    stall
);

  logic rsDep;
  logic rtDep;

  // RAW against the instruction now in execute
  assign rsDep = readingRs && (rsAddr == exWriteReg);
  assign rtDep = readingRt && (rtAddr == exWriteReg);

  // Older results are already in writeback and reachable through the bypass
  assign stall = instrValid && exRegWrite && (rsDep || rtDep);

endmodule

/* hdl/idExLatch.sv */
`timescale 1ns/1ps

module idExLatch import pipePkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    stall,
  input  instrWord                decInstr,
  input  logic [dataWidth-1:0]    pcIn,
  input  logic [dataWidth-1:0]    aData,
  input  logic [dataWidth-1:0]    bData,
  input  logic [dataWidth-1:0]    imm,
  input  logic [regAddrWidth-1:0] writeReg,
  input  logic                    regWrite,
  input  logic                    aluSrc2,
  input  logic                    invA,
  input  logic                    invB,
  input  logic                    cin,
  input  logic [aluOpWidth-1:0]   aluOp,
  output instrWord                exInstr,
  output logic [dataWidth-1:0]    exPc,
  output logic [dataWidth-1:0]    exA,
  output logic [dataWidth-1:0]    exB,
  output logic [dataWidth-1:0]    exImm,
  output logic [regAddrWidth-1:0] exWriteReg,
  output logic                    exRegWrite,
  output logic                    exAluSrc2,
  output logic                    exInvA,
  output logic                    exInvB,
  output logic                    exCin,
  output logic [aluOpWidth-1:0]   exAluOp
);

  instrWord instrOrBubble;
  logic regWriteOrBubble;

  // A stalled cycle turns into a NOP that writes nothing
  assign instrOrBubble = stall ? instrWord'(nopInstr) : decInstr;
  assign regWriteOrBubble = stall ? 1'b0 : regWrite;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exInstr <= nopInstr;
      exRegWrite <= 1'b0;
      exAluSrc2 <= 1'b0;
      exInvA <= 1'b0;
      exInvB <= 1'b0;
      exCin <= 1'b0;
      exAluOp <= aluAdd;
    end else begin
      exInstr <= instrOrBubble;
      exRegWrite <= regWriteOrBubble;
      exAluSrc2 <= aluSrc2;
      exInvA <= invA;
      exInvB <= invB;
      exCin <= cin;
      exAluOp <= aluOp;
    end
  end

  always_ff @(posedge clk) begin
    exPc <= pcIn;
    exA <= aData;
    exB <= bData;
    exImm <= imm;
    exWriteReg <= writeReg;
  end

  // The bubble clears the hazard, so the hazard unit drops stall next cycle
  stallOneCycle: assert property (
    @(posedge clk) disable iff (!rstN)
    stall |=> !stall
  ) else $error("idExLatch: stall held for two consecutive cycles");

endmodule

/* hdl/execStage.sv */
`timescale 1ns/1ps

module execStage import pipePkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    exA,
  input  logic [dataWidth-1:0]    exB,
  input  logic [dataWidth-1:0]    exImm,
  input  logic                    exAluSrc2,
  input  logic                    exInvA,
  input  logic                    exInvB,
  input  logic                    exCin,
  input  logic [aluOpWidth-1:0]   exAluOp,
  input  logic [regAddrWidth-1:0] exWriteReg,
  input  logic                    exRegWrite,
  output logic                    wbEn,
  output logic [regAddrWidth-1:0] wbReg,
  output logic [dataWidth-1:0]    wbData
);

  logic [dataWidth-1:0] opB;
  logic [dataWidth-1:0] aAdj;
  logic [dataWidth-1:0] bAdj;
  logic [dataWidth-1:0] sum;
  logic [dataWidth-1:0] aluOut;

  assign opB = exAluSrc2 ? exImm : exB;
  assign aAdj = exInvA ? ~exA : exA;
  assign bAdj = exInvB ? ~opB : opB;

  // Carry-out is dropped so results wrap at 16 bits
  assign sum = aAdj + bAdj + {{(dataWidth-1){1'b0}}, exCin};

  always_comb begin
    case (exAluOp)
      aluXor: aluOut = aAdj ^ bAdj;
      aluAndn: aluOut = aAdj & bAdj;
      default: aluOut = sum;
    endcase
  end

  // Writeback register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbEn <= 1'b0;
    end else begin
      wbEn <= exRegWrite;
    end
  end

  always_ff @(posedge clk) begin
    wbReg <= exWriteReg;
    wbData <= aluOut;
  end

endmodule

/* hdl/decodeExecTop.sv */
`timescale 1ns/1ps

module decodeExecTop import pipePkg::*; (
  input  logic                    clk,
  input  logic                    rstN,
  input  logic [dataWidth-1:0]    instr,
  input  logic                    instrValid,
  input  logic [dataWidth-1:0]    pc,
  output logic                    stall,
  output logic                    wbEn,
  output logic [regAddrWidth-1:0] wbReg,
  output logic [dataWidth-1:0]    wbData
);

  logic [regAddrWidth-1:0] rsAddr;
  logic [regAddrWidth-1:0] rtAddr;
  logic [regAddrWidth-1:0] writeReg;
  logic regWrite;
  logic readingRs;
  logic readingRt;
  logic aluSrc2;
  logic invA;
  logic invB;
  logic cin;
  logic [aluOpWidth-1:0] aluOp;
  logic [dataWidth-1:0] imm;
  instrWord decInstr;
  logic [dataWidth-1:0] rsData;
  logic [dataWidth-1:0] rtData;
  logic [dataWidth-1:0] exA;
  logic [dataWidth-1:0] exB;
  logic [dataWidth-1:0] exImm;
  logic [regAddrWidth-1:0] exWriteReg;
  logic exRegWrite;
  logic exAluSrc2;
  logic exInvA;
  logic exInvB;
  logic exCin;
  logic [aluOpWidth-1:0] exAluOp;

  instrDecode uDecode (
    .instr(instr), .instrValid(instrValid),
    .rsAddr(rsAddr), .rtAddr(rtAddr), .writeReg(writeReg), .regWrite(regWrite),
    .readingRs(readingRs), .readingRt(readingRt), .aluSrc2(aluSrc2),
    .invA(invA), .invB(invB), .cin(cin), .aluOp(aluOp), .imm(imm),
    .decInstr(decInstr)
  );

  regFile uRegFile (
    .clk(clk), .rstN(rstN), .rsAddr(rsAddr), .rtAddr(rtAddr),
    .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData),
    .rsData(rsData), .rtData(rtData)
  );

  hazardDetect uHazard (
    .rsAddr(rsAddr), .rtAddr(rtAddr), .readingRs(readingRs), .readingRt(readingRt),
    .instrValid(instrValid), .exRegWrite(exRegWrite), .exWriteReg(exWriteReg),
    .stall(stall)
  );

  // Operand A is zero when no source is read, which is how LBI loads its immediate
  idExLatch uIdEx (
    .clk(clk), .rstN(rstN), .stall(stall), .decInstr(decInstr), .pcIn(pc),
    .aData(readingRs ? rsData : '0), .bData(rtData), .imm(imm),
    .writeReg(writeReg), .regWrite(regWrite), .aluSrc2(aluSrc2),
    .invA(invA), .invB(invB), .cin(cin), .aluOp(aluOp),
    .exInstr(), .exPc(), .exA(exA), .exB(exB), .exImm(exImm),
    .exWriteReg(exWriteReg), .exRegWrite(exRegWrite), .exAluSrc2(exAluSrc2),
    .exInvA(exInvA), .exInvB(exInvB), .exCin(exCin), .exAluOp(exAluOp)
  );

  execStage uExec (
    .clk(clk), .rstN(rstN), .exA(exA), .exB(exB), .exImm(exImm),
    .exAluSrc2(exAluSrc2), .exInvA(exInvA), .exInvB(exInvB), .exCin(exCin),
    .exAluOp(exAluOp), .exWriteReg(exWriteReg), .exRegWrite(exRegWrite),
    .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

/* verif/decodeExecTb.sv */
`timescale 1ns/1ps

module decodeExecTb import pipePkg::*; ();

  localparam int numSeed = 8;
  localparam int numDirected = 11;
  localparam int numRandom = 200;
  localparam int maxCycles = 4 * (numSeed + numDirected + numRandom) + 50;

  logic clk;
  logic rstN;
  logic [dataWidth-1:0] instr;
  logic instrValid;
  logic [dataWidth-1:0] pc;
  logic stall;
  logic wbEn;
  logic [regAddrWidth-1:0] wbReg;
  logic [dataWidth-1:0] wbData;

  logic [31:0] rngState;
  logic [dataWidth-1:0] pcCount;
  int wbErrors;
  int stallErrors;
  int edgeCount;
  int watchCycles;

  // Reference model state
  logic [dataWidth-1:0] modelRegs [numRegs];
  logic [regAddrWidth-1:0] regQ[$];
  logic [dataWidth-1:0] dataQ[$];
  int dueQ[$];
  logic exWriteModel;
  logic [regAddrWidth-1:0] exRegModel;
  logic wantWbEn;
  logic [regAddrWidth-1:0] wantWbReg;
  logic [dataWidth-1:0] wantWbData;
  logic wantStall;
  instrWord cur;

  decodeExecTop uut (
    .clk(clk), .rstN(rstN), .instr(instr), .instrValid(instrValid), .pc(pc),
    .stall(stall), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic readsRs(input logic [4:0] op);
    return (op == opAddi) || (op == opSubi) || (op == opXori) || (op == opAndni) ||
           (op == opRtype);
  endfunction

  function automatic logic readsRt(input logic [4:0] op);
    return op == opRtype;
  endfunction

  function automatic logic writesReg(input logic [4:0] op);
    return readsRs(op) || (op == opLbi);
  endfunction

  function automatic logic [regAddrWidth-1:0] destOf(input instrWord w);
    if (w.rFmt.opcode == opLbi) begin
      return w.lFmt.rs;
    end else if (w.rFmt.opcode == opRtype) begin
      return w.rFmt.rd;
    end
    return w.iFmt.rd;
  endfunction

  // Expected result straight from the ISA rules
  function automatic logic [dataWidth-1:0] resultOf(input instrWord w,
      input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
    logic [dataWidth-1:0] s5;
    logic [dataWidth-1:0] z5;
    logic [dataWidth-1:0] s8;
    s5 = {{11{w.iFmt.imm5[4]}}, w.iFmt.imm5};
    z5 = {11'd0, w.iFmt.imm5};
    s8 = {{8{w.lFmt.imm8[7]}}, w.lFmt.imm8};
    case (w.rFmt.opcode)
      opAddi: return a + s5;
      opSubi: return s5 - a;
      opXori: return a ^ z5;
      opAndni: return a & ~z5;
      opLbi: return s8;
      default: begin
        case (w.rFmt.funct)
          fnAdd: return a + b;
          fnSub: return b - a;
          fnXor: return a ^ b;
          default: return a & ~b;
        endcase
      end
    endcase
  endfunction

  function automatic logic [dataWidth-1:0] encI(input logic [4:0] op,
      input logic [2:0] rs, input logic [2:0] rd, input logic [4:0] imm5);
    return {op, rs, rd, imm5};
  endfunction

  function automatic logic [dataWidth-1:0] encR(input logic [2:0] rs,
      input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] fn);
    return {opRtype, rs, rt, rd, fn};
  endfunction

  function automatic logic [dataWidth-1:0] encL(input logic [2:0] rs, input logic [7:0] imm8);
    return {opLbi, rs, imm8};
  endfunction

  // Mostly legal opcodes with an occasional NOP or arbitrary one
  function automatic logic [dataWidth-1:0] randomInstr(input logic [31:0] r);
    logic [4:0] op;
    case (r[30:28])
      3'd0: op = opAddi;
      3'd1: op = opSubi;
      3'd2: op = opXori;
      3'd3: op = opAndni;
      3'd4: op = opLbi;
      3'd7: op = r[31] ? opNop : r[27:23];
      default: op = opRtype;
    endcase
    return {op, r[15:5]};
  endfunction

  // Holds the word until the DUT takes it
  task automatic sendInstr(input logic [dataWidth-1:0] w);
    instr <= w;
    instrValid <= 1'b1;
    pc <= pcCount;
    @(posedge clk);
    while (stall) begin
      @(posedge clk);
    end
    pcCount = pcCount + 16'd2;
  endtask

  task automatic idleCycle(input logic [dataWidth-1:0] junk);
    instr <= junk;
    instrValid <= 1'b0;
    @(posedge clk);
  endtask

  assign cur = instr;
  assign wantStall = instrValid && exWriteModel &&
    ((readsRs(cur.rFmt.opcode) && cur.rFmt.rs == exRegModel) ||
     (readsRt(cur.rFmt.opcode) && cur.rFmt.rt == exRegModel));

  always @(posedge clk) begin : refModel
    instrWord w;
    logic [regAddrWidth-1:0] d;
    logic [dataWidth-1:0] v;
    edgeCount = edgeCount + 1;
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        modelRegs[i] = '0;
      end
      regQ.delete();
      dataQ.delete();
      dueQ.delete();
      exWriteModel <= 1'b0;
      wantWbEn <= 1'b0;
    end else begin
      if (dueQ.size() > 0 && dueQ[0] == edgeCount) begin
        wantWbEn <= 1'b1;
        wantWbReg <= regQ.pop_front();
        wantWbData <= dataQ.pop_front();
        void'(dueQ.pop_front());
      end else begin
        wantWbEn <= 1'b0;
      end
      exWriteModel <= 1'b0;
      // Acceptance edge moves architectural state in program order
      if (instrValid && !stall) begin
        w = instr;
        if (writesReg(w.rFmt.opcode)) begin
          d = destOf(w);
          v = resultOf(w, modelRegs[w.rFmt.rs], modelRegs[w.rFmt.rt]);
          modelRegs[d] = v;
          regQ.push_back(d);
          dataQ.push_back(v);
          dueQ.push_back(edgeCount + 1);
          exWriteModel <= 1'b1;
          exRegModel <= d;
        end
      end
    end
  end

  always @(posedge clk) begin
    watchCycles = watchCycles + 1;
    if (watchCycles > maxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", maxCycles);
      $display("Simulation failed");
      $finish;
    end
  end

  wbEnMatch: assert property (@(posedge clk) disable iff (!rstN) wbEn == wantWbEn)
    else begin
      wbErrors = wbErrors + 1;
      $display("[FAIL] wbEn got %h expected %h", $sampled(wbEn), $sampled(wantWbEn));
    end

  wbRegMatch: assert property (@(posedge clk) disable iff (!rstN)
    wbEn |-> wbReg == wantWbReg)
    else begin
      wbErrors = wbErrors + 1;
      $display("[FAIL] wbReg got %h expected %h", $sampled(wbReg), $sampled(wantWbReg));
    end

  wbDataMatch: assert property (@(posedge clk) disable iff (!rstN)
    wbEn |-> wbData == wantWbData)
    else begin
      wbErrors = wbErrors + 1;
      $display("[FAIL] wbData got %h expected %h", $sampled(wbData), $sampled(wantWbData));
    end

  stallMatch: assert property (@(posedge clk) disable iff (!rstN) stall == wantStall)
    else begin
      stallErrors = stallErrors + 1;
      $display("[FAIL] stall got %h expected %h", $sampled(stall), $sampled(wantStall));
    end

  stallOnce: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
    else begin
      stallErrors = stallErrors + 1;
      $display("Stall stayed high for two cycles in a row");
    end

  initial begin
    clk = 1'b0;
    rstN = 1'b0;
    instr = nopInstr;
    instrValid = 1'b0;
    pc = '0;
    pcCount = '0;
    rngState = 32'h6189_0d7b;
    wbErrors = 0;
    stallErrors = 0;
    edgeCount = 0;
    watchCycles = 0;
    repeat (2) @(posedge clk);
    rstN <= 1'b1;
    repeat (3) @(posedge clk);

    for (int r = 0; r < numSeed; r++) begin
      rngState = xorshift(rngState);
      sendInstr(encL(3'(r), rngState[7:0]));
    end

    // Negative immediates
    sendInstr(encL(3'd1, 8'h9c));
    sendInstr(encI(opAddi, 3'd2, 3'd3, 5'h13));
    sendInstr(encI(opSubi, 3'd4, 3'd5, 5'h1e));
    sendInstr(encI(opXori, 3'd6, 3'd7, 5'h11));
    sendInstr(encI(opAndni, 3'd0, 3'd2, 5'h1f));

    // Back-to-back RAW on r4
    sendInstr(encI(opAddi, 3'd1, 3'd4, 5'h01));
    sendInstr(encR(3'd4, 3'd1, 3'd6, fnSub));

    // r2 read two instructions after its write
    sendInstr(encL(3'd2, 8'h55));
    sendInstr(encI(opXori, 3'd0, 3'd3, 5'h0a));
    sendInstr(encR(3'd2, 3'd5, 3'd7, fnAndn));

    sendInstr(nopInstr);
    idleCycle(encR(3'd1, 3'd2, 3'd3, fnAdd));

    for (int i = 0; i < numRandom; i++) begin
      rngState = xorshift(rngState);
      if (rngState[3:0] < 4'd2) begin
        idleCycle(rngState[31:16]);
      end
      sendInstr(randomInstr(rngState));
    end

    instrValid <= 1'b0;
    @(posedge clk);
    while (dueQ.size() > 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);

    $display("Errors: writeback %0d, stall %0d", wbErrors, stallErrors);
    if (wbErrors + stallErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* project.f */
hdl/pipePkg.sv
hdl/regFile.sv
hdl/instrDecode.sv
hdl/hazardDetect.sv
hdl/idExLatch.sv
hdl/execStage.sv
hdl/decodeExecTop.sv
verif/decodeExecTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module decodeExecTb \
  -f project.f --Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  exit 1
fi
exit 0
